//--- src/trg_pkg.sv
`default_nettype none

package trg_pkg;

  // stream geometry
  localparam int unsigned tdata_width      = 128;
  localparam int unsigned slot_width       = 16;
  localparam int unsigned samples_per_beat = 8;
  localparam int unsigned adc_width        = 12;
  localparam int unsigned time_width       = 44;
  localparam int unsigned len_width        = 8;

  // register port
  localparam int unsigned cfg_addr_width = 3;
  localparam int unsigned cfg_data_width = 32;

  // exec state codes, 01 and 10 are paused
  localparam logic [1:0] exec_init = 2'b00;
  localparam logic [1:0] exec_trg  = 2'b11;

  localparam logic [cfg_addr_width-1:0] reg_exec      = 3'd0;
  localparam logic [cfg_addr_width-1:0] reg_baseline  = 3'd1;
  localparam logic [cfg_addr_width-1:0] reg_threshold = 3'd2;
  localparam logic [cfg_addr_width-1:0] reg_post_len  = 3'd3;
  localparam logic [cfg_addr_width-1:0] reg_max_len   = 3'd4;

  // ten percent of the 12-bit full scale
  localparam logic [adc_width-1:0] default_threshold = 12'd409;
  localparam logic [len_width-1:0] default_post_len  = 8'd38;
  localparam logic [len_width-1:0] default_max_len   = 8'd100;

  typedef struct packed {
    logic [1:0]                  exec;
    logic signed [adc_width-1:0] baseline;
    logic [adc_width-1:0]        threshold;
    logic [len_width-1:0]        post_len;
    logic [len_width-1:0]        max_len;
  } trg_cfg_t;

  typedef struct packed {
    logic [tdata_width-1:0] data;
    logic                   triggered;
  } trg_beat_t;

  // detect stage output, one per clock
  typedef struct packed {
    logic [tdata_width-1:0]      data;
    logic                        valid;
    logic                        hit;
    logic [time_width-1:0]       time_stamp;
    logic signed [adc_width-1:0] baseline;
  } trg_hit_t;

  typedef struct packed {
    logic [time_width-1:0]       time_stamp;
    logic signed [adc_width-1:0] baseline;
  } trg_event_t;

endpackage

`default_nettype wire

//--- src/trg_config.sv
`default_nettype none

module trg_config import trg_pkg::*; (
  input  wire                      AXIS_ACLK,
  input  wire                      AXIS_ARESETN,
  input  wire                      cfg_we,
  input  wire [cfg_addr_width-1:0] cfg_addr,
  input  wire [cfg_data_width-1:0] cfg_wdata,
  output trg_cfg_t                 cfg
);

  trg_cfg_t cfg_q;

  // each field takes the low bits of the written word
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      cfg_q.exec      <= exec_init;
      cfg_q.baseline  <= '0;
      cfg_q.threshold <= default_threshold;
      cfg_q.post_len  <= default_post_len;
      cfg_q.max_len   <= default_max_len;
    end else if (cfg_we) begin
      case (cfg_addr)
        reg_exec: begin
          cfg_q.exec <= cfg_wdata[1:0];
        end
        reg_baseline: begin
          cfg_q.baseline <= cfg_wdata[adc_width-1:0];
        end
        reg_threshold: begin
          cfg_q.threshold <= cfg_wdata[adc_width-1:0];
        end
        reg_post_len: begin
          cfg_q.post_len <= cfg_wdata[len_width-1:0];
        end
        reg_max_len: begin
          cfg_q.max_len <= cfg_wdata[len_width-1:0];
        end
        // addresses 5 to 7 are not decoded
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg = cfg_q;

endmodule

`default_nettype wire

//--- src/trg_timebase.sv
`default_nettype none

module trg_timebase import trg_pkg::*; (
  input  wire                   AXIS_ACLK,
  input  wire                   AXIS_ARESETN,
  input  trg_cfg_t              cfg,
  output logic [time_width-1:0] current_time
);

  // zero in init, counts in trg, holds while paused
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      current_time <= '0;
    end else if (cfg.exec == exec_init) begin
      current_time <= '0;
    end else if (cfg.exec == exec_trg) begin
      current_time <= current_time + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/trg_hit_detect.sv
`default_nettype none

module trg_hit_detect import trg_pkg::*; (
  input  wire                   AXIS_ACLK,
  input  wire                   AXIS_ARESETN,
  input  trg_cfg_t              cfg,
  input  wire [tdata_width-1:0] s_axis_tdata,
  input  wire                   s_axis_tvalid,
  input  wire [time_width-1:0]  current_time,
  output trg_hit_t              hit
);

  // two extra bits so sample minus baseline cannot wrap
  localparam int unsigned diff_width = adc_width + 2;

  logic [samples_per_beat-1:0] over_thr;

  always_comb begin
    logic signed [adc_width-1:0]  sample;
    logic signed [diff_width-1:0] diff;
    for (int i = 0; i < samples_per_beat; i++) begin
      // ADC value sits in the top bits of its slot
      sample = s_axis_tdata[slot_width*i + slot_width-1 -: adc_width];
      diff = diff_width'(sample) - diff_width'(cfg.baseline);
      over_thr[i] = (diff >= $signed({2'b00, cfg.threshold}));
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      hit.valid <= 1'b0;
      hit.hit   <= 1'b0;
    end else begin
      hit.valid <= s_axis_tvalid;
      hit.hit   <= s_axis_tvalid && (|over_thr);
    end
  end

  // beat payload with its time and baseline
  always_ff @(posedge AXIS_ACLK) begin
    hit.data       <= s_axis_tdata;
    hit.time_stamp <= current_time;
    hit.baseline   <= cfg.baseline;
  end

endmodule

`default_nettype wire

//--- src/trg_window.sv
`default_nettype none

module trg_window import trg_pkg::*; (
  input  wire         AXIS_ACLK,
  input  wire         AXIS_ARESETN,
  input  trg_cfg_t    cfg,
  input  trg_hit_t    hit,
  output trg_beat_t   out_beat,
  output logic        out_valid,
  output trg_event_t  event_data,
  output logic        event_valid
);

  // one bit wider than the lengths so saturation is out of reach
  localparam int unsigned cnt_width = len_width + 1;
  localparam logic [cnt_width-1:0] cnt_sat = '1;

  logic [cnt_width-1:0] post_cnt;
  logic [cnt_width-1:0] full_cnt;
  logic                 prev_hit;
  logic                 win_open;

  logic                 run;
  logic                 start;
  logic [cnt_width-1:0] post_idx;
  logic [cnt_width-1:0] full_idx;
  logic                 in_len;
  logic                 in_post;
  logic                 trig;

  assign run = hit.valid && (cfg.exec == exec_trg);

  // a re-hit while the window is still open only extends it
  assign start = hit.hit && !prev_hit && !win_open;

  // valid beats since last hit and since window start
  always_comb begin
    if (hit.hit) begin
      post_idx = '0;
    end else if (post_cnt == cnt_sat) begin
      post_idx = post_cnt;
    end else begin
      post_idx = post_cnt + 1'b1;
    end

    if (start) begin
      full_idx = '0;
    end else if (full_cnt == cnt_sat) begin
      full_idx = full_cnt;
    end else begin
      full_idx = full_cnt + 1'b1;
    end
  end

  assign in_len  = (full_idx < {1'b0, cfg.max_len});
  assign in_post = hit.hit || (post_idx <= {1'b0, cfg.post_len});
  assign trig    = run && in_len && in_post;

  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      post_cnt <= cnt_sat;
      full_cnt <= cnt_sat;
      prev_hit <= 1'b0;
      win_open <= 1'b0;
    end else if (cfg.exec == exec_init) begin
      post_cnt <= cnt_sat;
      full_cnt <= cnt_sat;
      prev_hit <= 1'b0;
      win_open <= 1'b0;
    end else if (run) begin
      post_cnt <= post_idx;
      full_cnt <= full_idx;
      prev_hit <= hit.hit;
      win_open <= trig;
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      out_valid          <= 1'b0;
      out_beat.triggered <= 1'b0;
      event_valid        <= 1'b0;
    end else begin
      out_valid          <= hit.valid;
      out_beat.triggered <= trig;
      event_valid        <= trig && start;
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    out_beat.data <= hit.data;
    // event payload follows the window start beat
    if (trig && start) begin
      event_data.time_stamp <= hit.time_stamp;
      event_data.baseline   <= hit.baseline;
    end
  end

endmodule

`default_nettype wire

//--- src/trg_top.sv
`default_nettype none

module trg_top import trg_pkg::*; (
  input  wire                      AXIS_ACLK,
  input  wire                      AXIS_ARESETN,
  input  wire                      cfg_we,
  input  wire [cfg_addr_width-1:0] cfg_addr,
  input  wire [cfg_data_width-1:0] cfg_wdata,
  input  wire [tdata_width-1:0]    s_axis_tdata,
  input  wire                      s_axis_tvalid,
  output trg_beat_t                out_beat,
  output logic                     out_valid,
  output trg_event_t               event_data,
  output logic                     event_valid
);

  trg_cfg_t              cfg;
  logic [time_width-1:0] current_time;
  trg_hit_t              hit;

  // register block shared by all stages
  trg_config config_i (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg          (cfg)
  );

  trg_timebase timebase_i (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .cfg          (cfg),
    .current_time (current_time)
  );

  // stage one, threshold compare
  trg_hit_detect hit_detect_i (
    .AXIS_ACLK     (AXIS_ACLK),
    .AXIS_ARESETN  (AXIS_ARESETN),
    .cfg           (cfg),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .current_time  (current_time),
    .hit           (hit)
  );

  // stage two, window and event
  trg_window window_i (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .cfg          (cfg),
    .hit          (hit),
    .out_beat     (out_beat),
    .out_valid    (out_valid),
    .event_data   (event_data),
    .event_valid  (event_valid)
  );

endmodule

`default_nettype wire

//--- tests/trg_checker.sv
`default_nettype none

module trg_checker import trg_pkg::*; (
  input wire             AXIS_ACLK,
  input wire             AXIS_ARESETN,
  input wire trg_beat_t  out_beat,
  input wire             out_valid,
  input wire trg_event_t event_data,
  input wire             event_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  trg_beat_t  beat_q[$];
  trg_event_t event_q[$];

  int data_errors  = 0;
  int trig_errors  = 0;
  int event_errors = 0;
  int other_errors = 0;

  task automatic expect_beat(input logic [tdata_width-1:0] data, input logic triggered);
    trg_beat_t b;
    b.data      = data;
    b.triggered = triggered;
    beat_q.push_back(b);
  endtask

  task automatic expect_event(input logic [time_width-1:0] ts, input logic [adc_width-1:0] base);
    trg_event_t e;
    e.time_stamp = ts;
    e.baseline   = base;
    event_q.push_back(e);
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    other_errors++;
  endtask

  function automatic bit queues_empty();
    return (beat_q.size() == 0) && (event_q.size() == 0);
  endfunction

  function automatic int total_errors();
    return data_errors + trig_errors + event_errors + other_errors;
  endfunction

  task automatic report_leftover();
    if (beat_q.size() != 0) begin
      report_problem($sformatf("%0d expected beats never came out", beat_q.size()));
    end
    if (event_q.size() != 0) begin
      report_problem($sformatf("%0d expected events never came out", event_q.size()));
    end
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge AXIS_ACLK) begin
    trg_beat_t  exp_beat;
    trg_event_t exp_event;
    if (AXIS_ARESETN && out_valid) begin
      if (beat_q.size() == 0) begin
        report_problem("an output beat came out while no beat was expected");
      end else begin
        exp_beat = beat_q.pop_front();
        if (out_beat.data !== exp_beat.data) begin
          $display("error: out_beat.data got %h expected %h", out_beat.data, exp_beat.data);
          data_errors++;
        end
        if (out_beat.triggered !== exp_beat.triggered) begin
          $display("error: out_beat.triggered got %h expected %h",
                   out_beat.triggered, exp_beat.triggered);
          trig_errors++;
        end
      end
    end
    if (AXIS_ARESETN && event_valid) begin
      if (event_q.size() == 0) begin
        report_problem("an event came out while no event was expected");
      end else begin
        exp_event = event_q.pop_front();
        if (event_data !== exp_event) begin
          $display("error: event_data got %h expected %h", event_data, exp_event);
          event_errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/trg_sva.sv
`default_nettype none

module trg_sva import trg_pkg::*; (
  input wire            AXIS_ACLK,
  input wire            AXIS_ARESETN,
  input wire trg_beat_t out_beat,
  input wire            out_valid,
  input wire            event_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // event flag of the last valid output beat
  logic last_had_event;

  always @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      last_had_event <= 1'b0;
    end else if (out_valid) begin
      last_had_event <= event_valid;
    end
  end

  reset_quiet: assert property (@(posedge AXIS_ACLK)
    !AXIS_ARESETN |=> (!out_valid && !event_valid))
    else $error("outputs active during or just after reset");

  event_on_trig: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
    event_valid |-> (out_valid && out_beat.triggered))
    else $error("event without a triggered output beat");

  no_back_to_back: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
    (out_valid && event_valid) |-> !last_had_event)
    else $error("events on two consecutive valid beats");

endmodule

bind trg_top trg_sva sva_i (
  .AXIS_ACLK    (AXIS_ACLK),
  .AXIS_ARESETN (AXIS_ARESETN),
  .out_beat     (out_beat),
  .out_valid    (out_valid),
  .event_valid  (event_valid)
);

`default_nettype wire

//--- tests/tb_trg_top.sv
`default_nettype none

module tb_trg_top import trg_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam string trace_path = "tests/trg_trace.txt";

  logic                      AXIS_ACLK = 1'b0;
  logic                      AXIS_ARESETN;
  logic                      cfg_we;
  logic [cfg_addr_width-1:0] cfg_addr;
  logic [cfg_data_width-1:0] cfg_wdata;
  logic [tdata_width-1:0]    s_axis_tdata;
  logic                      s_axis_tvalid;
  trg_beat_t                 out_beat;
  logic                      out_valid;
  trg_event_t                event_data;
  logic                      event_valid;

  string lines[$];
  bit    trace_loaded = 1'b0;

  always #5 AXIS_ACLK = ~AXIS_ACLK;

  trg_top trg_top_i (
    .AXIS_ACLK     (AXIS_ACLK),
    .AXIS_ARESETN  (AXIS_ARESETN),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .event_data    (event_data),
    .event_valid   (event_valid)
  );

  trg_checker chk_i (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .out_beat     (out_beat),
    .out_valid    (out_valid),
    .event_data   (event_data),
    .event_valid  (event_valid)
  );

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge AXIS_ACLK);
    #1;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    cfg_addr  = addr[cfg_addr_width-1:0];
    cfg_wdata = data;
    cfg_we    = 1'b1;
    next_cycle();
    cfg_we = 1'b0;
  endtask

  task automatic send_beat(input logic [tdata_width-1:0] data);
    s_axis_tdata  = data;
    s_axis_tvalid = 1'b1;
    next_cycle();
    s_axis_tvalid = 1'b0;
  endtask

  task automatic load_trace();
    int    fd;
    string line;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      chk_i.report_problem("could not open the trace file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        lines.push_back(line);
      end
      $fclose(fd);
    end
    trace_loaded = 1'b1;
  endtask

  task automatic run_line(input string line, input int num);
    string                  rest;
    int                     cnt;
    logic [31:0]            a;
    logic [31:0]            d;
    logic [adc_width-1:0]   smp [samples_per_beat];
    logic                   trig;
    logic [tdata_width-1:0] data;
    logic [time_width-1:0]  ts;
    logic [adc_width-1:0]   base;
    if (line.len() < 2) begin
      return;
    end
    rest = line.substr(1, line.len() - 1);
    case (line[0])
      "#": begin
      end
      "w": begin
        cnt = $sscanf(rest, "%h %h", a, d);
        if (cnt == 2) begin
          write_reg(a, d);
        end else begin
          chk_i.report_problem($sformatf("trace line %0d is not a valid write", num));
        end
      end
      "i": begin
        cnt = $sscanf(rest, "%d", a);
        if (cnt == 1) begin
          repeat (a) next_cycle();
        end else begin
          chk_i.report_problem($sformatf("trace line %0d is not a valid idle gap", num));
        end
      end
      "b": begin
        cnt = $sscanf(rest, "%h %h %h %h %h %h %h %h %h", smp[0], smp[1], smp[2], smp[3],
                      smp[4], smp[5], smp[6], smp[7], trig);
        if (cnt == 9) begin
          // each ADC value sits in the top 12 bits of its slot
          for (int i = 0; i < samples_per_beat; i++) begin
            data[slot_width*i +: slot_width] = {smp[i], 4'h0};
          end
          chk_i.expect_beat(data, trig);
          send_beat(data);
        end else begin
          chk_i.report_problem($sformatf("trace line %0d is not a valid beat", num));
        end
      end
      "e": begin
        cnt = $sscanf(rest, "%h %h", ts, base);
        if (cnt == 2) begin
          chk_i.expect_event(ts, base);
        end else begin
          chk_i.report_problem($sformatf("trace line %0d is not a valid event", num));
        end
      end
      default: begin
        chk_i.report_problem($sformatf("trace line %0d has an unknown kind", num));
      end
    endcase
  endtask

  initial begin
    int total;
    int drain;
    AXIS_ARESETN  = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    load_trace();
    repeat (16) @(posedge AXIS_ACLK);
    #1;
    AXIS_ARESETN = 1'b1;
    foreach (lines[i]) begin
      run_line(lines[i], i + 1);
    end
    // two pipeline stages, so the last outputs follow within a few cycles
    drain = 0;
    while (!chk_i.queues_empty() && drain < 8) begin
      next_cycle();
      drain++;
    end
    // a few more cycles to catch stray outputs
    repeat (3) next_cycle();
    chk_i.report_leftover();
    total = chk_i.total_errors();
    $display("errors: data %0d, triggered %0d, event %0d, other %0d", chk_i.data_errors,
             chk_i.trig_errors, chk_i.event_errors, chk_i.other_errors);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // limit grows with the trace length
  initial begin
    int limit;
    wait (trace_loaded);
    limit = 20 * lines.size() + 200;
    repeat (limit) @(posedge AXIS_ACLK);
    $display("timeout: the run did not finish within %0d clock cycles", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/trg_trace.txt
# w addr data | i cycles | b s0 s1 s2 s3 s4 s5 s6 s7 triggered | e time baseline
# values in hex except the idle count, s0 is the lowest slot
w 3 2
b 7ff 000 000 000 000 000 000 000 0
w 0 1
b 7ff 000 000 000 000 000 000 000 0
i 2
w 0 3
b 198 000 000 000 000 000 000 000 0
e 1 0
b 000 000 000 000 000 000 000 199 1
b 000 000 000 000 000 000 000 000 1
i 3
b 000 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 0
e 8 0
b 7ff 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 1
b 7ff 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 0
w 1 f9c
b 134 000 000 000 000 000 000 000 0
e 10 f9c
b 135 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 0
w 1 0
w 4 5
e 16 0
b 7ff 000 000 000 000 000 000 000 1
b 7ff 000 000 000 000 000 000 000 1
b 7ff 000 000 000 000 000 000 000 1
b 7ff 000 000 000 000 000 000 000 1
b 7ff 000 000 000 000 000 000 000 1
b 7ff 000 000 000 000 000 000 000 0
b 7ff 000 000 000 000 000 000 000 0
b 000 000 000 000 000 000 000 000 0
e 1e 0
b 7ff 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 1
w 3 0
b 000 000 000 000 000 000 000 000 0
w 2 400
b 3ff 000 000 000 000 000 000 000 0
e 24 0
b 400 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 0
w 7 ff
e 27 0
b 400 000 000 000 000 000 000 000 1
b 000 000 000 000 000 000 000 000 0
w 0 1
b 7ff 000 000 000 000 000 000 000 0
w 0 0
b 7ff 000 000 000 000 000 000 000 0

//--- sources.f
src/trg_pkg.sv
src/trg_config.sv
src/trg_timebase.sv
src/trg_hit_detect.sv
src/trg_window.sv
src/trg_top.sv
tests/trg_checker.sv
tests/trg_sva.sv
tests/tb_trg_top.sv

//--- Makefile
# Verilator build and run for the trigger front end

VERILATOR ?= verilator
TOP       ?= tb_trg_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
